// ==== Bender.yml ====
package:
  name: ipv4_header_parser

sources:
  # Design, package first
  - rtl/frame_parse_pkg.sv
  - rtl/byte_beat_if.sv
  - rtl/frame_sequencer.sv
  - rtl/header_field_capture.sv
  - rtl/payload_forwarder.sv
  - rtl/ipv4_header_parser.sv

  # Testbench
  - target: test
    files:
      - tb/parser_checks.sv
      - tb/tb_ipv4_header_parser.sv

// ==== rtl/byte_beat_if.sv ====
//--------------------------------------------------------------------
// Accepted byte stream from the sequencer to capture and forwarding
//--------------------------------------------------------------------

interface byte_beat_if
    import frame_parse_pkg::*;
();

    logic        beat;
    byte_t       data;
    logic        last;
    byte_index_t index;
    logic        in_header;
    logic        ready;

    modport source (output beat, data, last, index, in_header, input ready);

    // Forwarder owns the back-pressure
    modport sink (input beat, data, last, index, in_header, output ready);

    // Observes only, no say in ready
    modport monitor (input beat, data, last, index, in_header);

endinterface

// ==== rtl/frame_parse_pkg.sv ====
//--------------------------------------------------------------------
// Stream widths, IPv4 header record and sequencer state encoding
//--------------------------------------------------------------------

package frame_parse_pkg;

    //----------------------------------------------------------------
    // Stream geometry
    //----------------------------------------------------------------

    // One byte per stream beat
    localparam int BYTE_WIDTH   = 8;

    // Fixed IPv4 header without options
    localparam int HEADER_BYTES = 20;

    typedef logic [BYTE_WIDTH-1:0] byte_t;

    // Position inside a frame, stops counting at HEADER_BYTES
    typedef logic [4:0] byte_index_t;

    //----------------------------------------------------------------
    // Header layout
    //----------------------------------------------------------------

    // Fields in wire order, first byte on the wire lands in the MSBs.
    // The byte offset of each field follows from its place in the record.
    typedef struct packed {
        logic [7:0]  version_ihl;
        logic [7:0]  tos;
        logic [15:0] total_length;
        logic [15:0] identification;
        // Three flag bits above the 13-bit fragment offset
        logic [15:0] flags_fragment;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ipv4_header_t;

    //----------------------------------------------------------------
    // Sequencer phases
    //----------------------------------------------------------------

    // IDLE waits for the first byte of a frame
    // HEADER collects bytes 1 to 19
    // PAYLOAD passes bytes on until last
    // DISCARD drops a frame that began with enable low
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        HEADER  = 2'd1,
        PAYLOAD = 2'd2,
        DISCARD = 2'd3
    } parse_state_t;

endpackage

// ==== rtl/frame_sequencer.sv ====
//--------------------------------------------------------------------
// Frame sequencer, byte position and phase tracking with enable and
// short frame handling
//--------------------------------------------------------------------

module frame_sequencer
    import frame_parse_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        enable,
    input  byte_t       in_data,
    input  logic        in_valid,
    input  logic        in_last,
    output logic        in_ready,
    byte_beat_if.source beats
);

    parse_state_t state;
    parse_state_t state_next;
    byte_index_t  byte_idx;
    logic         accept;
    logic         header_byte;
    logic         frame_kept;

    // Input waits whenever the output register is stalled
    assign in_ready = beats.ready;
    assign accept   = in_valid && beats.ready;

    // Phase of the byte now on the input.
    // The first byte of a frame is decided by enable while still in IDLE
    assign header_byte = (state == HEADER) || ((state == IDLE) && enable);
    assign frame_kept  = header_byte || (state == PAYLOAD);

    assign beats.beat      = accept && frame_kept;
    assign beats.data      = in_data;
    assign beats.last      = in_last;
    assign beats.index     = byte_idx;
    assign beats.in_header = header_byte;

    //----------------------------------------------------------------
    // Next phase, evaluated only on an accepted byte
    //----------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (!in_last) begin
                    state_next = enable ? HEADER : DISCARD;
                end
            end
            HEADER: begin
                // Last byte inside the header abandons the frame
                if (in_last) begin
                    state_next = IDLE;
                end else if (byte_idx == byte_index_t'(HEADER_BYTES - 1)) begin
                    state_next = PAYLOAD;
                end
            end
            default: begin
                if (in_last) begin
                    state_next = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            byte_idx <= '0;
        end else if (accept) begin
            state <= state_next;
            if (in_last) begin
                byte_idx <= '0;
            end else if (byte_idx != byte_index_t'(HEADER_BYTES)) begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    // Payload bytes all share the saturated index
    assert property (@(posedge clock) disable iff (!rst_n)
        byte_idx <= byte_index_t'(HEADER_BYTES))
        else $error("byte index ran past the header length");

endmodule

// ==== rtl/header_field_capture.sv ====
//--------------------------------------------------------------------
// Header byte capture into the IPv4 record and header valid flag
//--------------------------------------------------------------------

module header_field_capture
    import frame_parse_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    byte_beat_if.monitor beats,
    output ipv4_header_t header,
    output logic         header_valid
);

    byte_index_t byte_slot;
    logic        header_beat;
    logic        header_done;
    logic        frame_end;

    // Byte 0 goes to the top of the record
    assign byte_slot = byte_index_t'(HEADER_BYTES - 1) - beats.index;

    assign header_beat = beats.beat && beats.in_header;
    assign frame_end   = beats.beat && beats.last;

    // Final header byte with more to follow
    assign header_done = header_beat && !beats.last &&
                         (beats.index == byte_index_t'(HEADER_BYTES - 1));

    //----------------------------------------------------------------
    // Field storage
    //----------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            header <= '0;
        end else if (header_beat) begin
            header[byte_slot * BYTE_WIDTH +: BYTE_WIDTH] <= beats.data;
        end
    end

    //----------------------------------------------------------------
    // Valid flag, held from header end to frame end
    //----------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            header_valid <= 1'b0;
        end else if (frame_end) begin
            header_valid <= 1'b0;
        end else if (header_done) begin
            header_valid <= 1'b1;
        end
    end

    // Previous frame must have ended before the next header starts
    assert property (@(posedge clock) disable iff (!rst_n)
        (header_beat && (beats.index == byte_index_t'(0))) |-> !header_valid)
        else $error("new header started while header_valid was still high");

endmodule

// ==== rtl/ipv4_header_parser.sv ====
//--------------------------------------------------------------------
// IPv4 header parser top, sequencer feeding field capture and payload
// forwarding, header record split onto plain field ports
//--------------------------------------------------------------------

module ipv4_header_parser
    import frame_parse_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    enable,

    // Byte stream in
    input  byte_t                   in_data,
    input  logic                    in_valid,
    input  logic                    in_last,
    output logic                    in_ready,

    // Payload stream out
    output byte_t                   out_data,
    output logic                    out_valid,
    output logic                    out_last,
    input  logic                    out_ready,

    // Parsed header
    output logic                    header_valid,
    output byte_t                   version_ihl,
    output byte_t                   tos,
    output logic [2*BYTE_WIDTH-1:0] total_length,
    output logic [2*BYTE_WIDTH-1:0] identification,
    output logic [2*BYTE_WIDTH-1:0] flags_fragment,
    output byte_t                   ttl,
    output byte_t                   protocol,
    output logic [2*BYTE_WIDTH-1:0] header_checksum,
    output logic [4*BYTE_WIDTH-1:0] src_addr,
    output logic [4*BYTE_WIDTH-1:0] dst_addr
);

    ipv4_header_t header;

    byte_beat_if beats ();

    frame_sequencer u_sequencer (
        .clock    (clock),
        .rst_n    (rst_n),
        .enable   (enable),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_last  (in_last),
        .in_ready (in_ready),
        .beats    (beats.source)
    );

    header_field_capture u_capture (
        .clock        (clock),
        .rst_n        (rst_n),
        .beats        (beats.monitor),
        .header       (header),
        .header_valid (header_valid)
    );

    payload_forwarder u_forwarder (
        .clock     (clock),
        .rst_n     (rst_n),
        .beats     (beats.sink),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    //----------------------------------------------------------------
    // Record to field ports
    //----------------------------------------------------------------
    assign version_ihl     = header.version_ihl;
    assign tos             = header.tos;
    assign total_length    = header.total_length;
    assign identification  = header.identification;
    assign flags_fragment  = header.flags_fragment;
    assign ttl             = header.ttl;
    assign protocol        = header.protocol;
    assign header_checksum = header.header_checksum;
    assign src_addr        = header.src_addr;
    assign dst_addr        = header.dst_addr;

endmodule

// ==== rtl/payload_forwarder.sv ====
//--------------------------------------------------------------------
// Payload output register, one deep, with back-pressure
//--------------------------------------------------------------------

module payload_forwarder
    import frame_parse_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    byte_beat_if.sink beats,
    output byte_t     out_data,
    output logic      out_valid,
    output logic      out_last,
    input  logic      out_ready
);

    logic load;

    // Register can take a byte when empty or being drained this cycle
    assign beats.ready = !out_valid || out_ready;

    // Sequencer only strobes beat on an accepted byte
    assign load = beats.beat && !beats.in_header;

    //----------------------------------------------------------------
    // Control
    //----------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
            out_last  <= beats.last;
        end else if (out_ready) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    //----------------------------------------------------------------
    // Data
    //----------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (load) begin
            out_data <= beats.data;
        end
    end

    // Held byte may not change or vanish under back-pressure
    assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_data) && $stable(out_last)))
        else $error("output byte changed while stalled");

endmodule

// ==== tb/parser_checks.sv ====
//--------------------------------------------------------------------
// Reference model of the parser and assertions on the DUT ports
//--------------------------------------------------------------------

module parser_checks
    import frame_parse_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    input  logic         enable,
    input  byte_t        in_data,
    input  logic         in_valid,
    input  logic         in_last,
    input  logic         in_ready,
    input  byte_t        out_data,
    input  logic         out_valid,
    input  logic         out_last,
    input  logic         out_ready,
    input  logic         header_valid,
    input  ipv4_header_t fields,
    output int           value_errors,
    output int           other_errors,
    output int           pending
);

    timeunit 1ns;
    timeprecision 1ps;

    logic              accept;
    logic              drop_now;
    logic              in_frame;
    logic              keep;
    logic              kept;
    int                pos;
    // Header bytes as they came off the wire
    byte_t             hdr_bytes [HEADER_BYTES];
    ipv4_header_t      exp_hdr;
    logic              exp_hv;
    logic [BYTE_WIDTH:0] head;
    // Expected payload, last flag above the data byte
    logic [BYTE_WIDTH:0] exp_q [$];

    assign accept   = in_valid && in_ready;
    // Byte that belongs to a frame begun with enable low
    assign drop_now = accept && (in_frame ? !keep : !enable);

    // Header bytes joined big-endian, first byte on the wire ends up on top
    always_comb begin
        exp_hdr = '0;
        for (int b = 0; b < HEADER_BYTES; b++) begin
            exp_hdr = {exp_hdr[$bits(ipv4_header_t)-BYTE_WIDTH-1:0], hdr_bytes[b]};
        end
    end

    //----------------------------------------------------------------
    // Reference model, header bytes in wire order, payload queued
    //----------------------------------------------------------------
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            in_frame <= 1'b0;
            keep     <= 1'b0;
            pos      <= 0;
            for (int b = 0; b < HEADER_BYTES; b++) begin
                hdr_bytes[b] <= '0;
            end
            exp_hv   <= 1'b0;
            exp_q.delete();
        end else begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("Payload byte %h came out with no byte expected", out_data);
                end else begin
                    head = exp_q.pop_front();
                    assert (out_data == head[BYTE_WIDTH-1:0]) else begin
                        value_errors++;
                        $display("CHECK FAILED payload_data: expected %h, actual %h",
                                 head[BYTE_WIDTH-1:0], out_data);
                    end
                    assert (out_last == head[BYTE_WIDTH]) else begin
                        value_errors++;
                        $display("CHECK FAILED payload_last: expected %b, actual %b",
                                 head[BYTE_WIDTH], out_last);
                    end
                end
            end
            if (accept) begin
                // Enable only counts on the first byte of a frame
                kept = in_frame ? keep : enable;
                if (kept && pos < HEADER_BYTES) begin
                    hdr_bytes[pos] <= in_data;
                end
                if (kept && pos >= HEADER_BYTES) begin
                    exp_q.push_back({in_last, in_data});
                end
                if (kept && in_last) begin
                    exp_hv <= 1'b0;
                end else if (kept && pos == HEADER_BYTES - 1) begin
                    exp_hv <= 1'b1;
                end
                in_frame <= !in_last;
                keep     <= kept;
                pos      <= in_last ? 0 : pos + 1;
            end
        end
        pending = exp_q.size();
    end

    //----------------------------------------------------------------
    // Port checks
    //----------------------------------------------------------------
    assert property (@(posedge clock) $rose(rst_n) |->
        !header_valid && !out_valid && !out_last && in_ready)
        else begin
            value_errors++;
            $display("CHECK FAILED reset_state: expected 0001, actual %b",
                     $sampled({header_valid, out_valid, out_last, in_ready}));
        end

    assert property (@(posedge clock) disable iff (!rst_n) header_valid == exp_hv)
        else begin
            value_errors++;
            $display("CHECK FAILED header_valid: expected %b, actual %b",
                     $sampled(exp_hv), $sampled(header_valid));
        end

    assert property (@(posedge clock) disable iff (!rst_n) $rose(header_valid) |-> fields == exp_hdr)
        else begin
            value_errors++;
            $display("CHECK FAILED header_fields: expected %h, actual %h",
                     $sampled(exp_hdr), $sampled(fields));
        end

    assert property (@(posedge clock) disable iff (!rst_n) drop_now |=> $stable(fields))
        else begin
            value_errors++;
            $display("CHECK FAILED discard_fields: expected %h, actual %h",
                     $sampled(exp_hdr), $sampled(fields));
        end

    assert property (@(posedge clock) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
        else begin
            other_errors++;
            $display("Output byte changed or vanished while out_ready was low");
        end

endmodule

// ==== tb/tb_ipv4_header_parser.sv ====
//--------------------------------------------------------------------
// Testbench for the IPv4 header parser, frame stimulus and watchdog
//--------------------------------------------------------------------

module tb_ipv4_header_parser
    import frame_parse_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD    = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int DRIVE_DELAY     = 2;
    localparam int STALL_ALLOWANCE = 8;
    localparam int FRAME_COUNT     = 12;

    // Short frames at 12, 19, 1 and 20 bytes, enable low on 30 and 25
    localparam int FRAME_LEN [FRAME_COUNT] = '{28, 45, 12, 33, 30, 21, 19, 1, 64, 20, 25, 26};
    localparam bit FRAME_EN  [FRAME_COUNT] = '{1, 1, 1, 1, 0, 1, 1, 1, 1, 1, 0, 1};

    function automatic int total_frame_bytes();
        int sum;
        sum = 0;
        for (int f = 0; f < FRAME_COUNT; f++) begin
            sum += FRAME_LEN[f];
        end
        return sum;
    endfunction

    localparam int WATCHDOG_CYCLES = (total_frame_bytes() + RESET_CYCLES) * STALL_ALLOWANCE;

    integer       seed = 67;
    logic         clock;
    logic         rst_n;
    logic         enable;
    byte_t        in_data;
    logic         in_valid;
    logic         in_last;
    logic         in_ready;
    byte_t        out_data;
    logic         out_valid;
    logic         out_last;
    logic         out_ready;
    logic         header_valid;
    logic [7:0]   version_ihl, tos, ttl, protocol;
    logic [15:0]  total_length, identification, flags_fragment, header_checksum;
    logic [31:0]  src_addr, dst_addr;
    ipv4_header_t dut_fields;
    int           value_errors;
    int           other_errors;
    int           pending;

    assign dut_fields = {version_ihl, tos, total_length, identification, flags_fragment,
                         ttl, protocol, header_checksum, src_addr, dst_addr};

    ipv4_header_parser UUT (
        .clock (clock), .rst_n (rst_n), .enable (enable),
        .in_data (in_data), .in_valid (in_valid), .in_last (in_last), .in_ready (in_ready),
        .out_data (out_data), .out_valid (out_valid), .out_last (out_last),
        .out_ready (out_ready), .header_valid (header_valid),
        .version_ihl (version_ihl), .tos (tos), .total_length (total_length),
        .identification (identification), .flags_fragment (flags_fragment),
        .ttl (ttl), .protocol (protocol), .header_checksum (header_checksum),
        .src_addr (src_addr), .dst_addr (dst_addr)
    );

    parser_checks checks (
        .clock (clock), .rst_n (rst_n), .enable (enable),
        .in_data (in_data), .in_valid (in_valid), .in_last (in_last), .in_ready (in_ready),
        .out_data (out_data), .out_valid (out_valid), .out_last (out_last),
        .out_ready (out_ready), .header_valid (header_valid), .fields (dut_fields),
        .value_errors (value_errors), .other_errors (other_errors), .pending (pending)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Advance one clock, then pick a new out_ready with roughly one stall in four
    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
        out_ready = ($random(seed) % 4) != 0;
    endtask

    task automatic send_byte(input byte_t data, input logic last, input logic en);
        logic taken;
        taken    = 1'b0;
        in_data  = data;
        in_last  = last;
        enable   = en;
        in_valid = 1'b1;
        while (!taken) begin
            @(negedge clock);
            taken = in_ready;
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    task automatic send_frame(input int len, input logic en);
        for (int i = 0; i < len; i++) begin
            if ($random(seed) % 5 == 0) begin
                next_cycle();
            end
            // Enable after the first byte is noise the parser must ignore
            send_byte(byte_t'($random(seed)), i == len - 1,
                      (i == 0) ? en : ($random(seed) % 2 != 0));
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        enable    = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        next_cycle();
        for (int f = 0; f < FRAME_COUNT; f++) begin
            send_frame(FRAME_LEN[f], FRAME_EN[f]);
        end
        // A lost byte keeps this loop waiting until the watchdog fires
        while (pending != 0 || out_valid) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired before all frames were parsed and drained");
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/frame_parse_pkg.sv
rtl/byte_beat_if.sv
rtl/frame_sequencer.sv
rtl/header_field_capture.sv
rtl/payload_forwarder.sv
rtl/ipv4_header_parser.sv
tb/parser_checks.sv
tb/tb_ipv4_header_parser.sv
